//--- logic/cpu_pkg.sv
package cpu_pkg;

    // Instruction layout
    localparam int INSTR_BITS    = 16;
    localparam int OPCODE_BITS   = 4;
    localparam int REG_ADDR_BITS = 3;
    localparam int IMM_BITS      = 8;

    // Field positions inside the instruction word
    localparam int DEST_LSB  = 8;
    localparam int SRC_A_LSB = 4;
    localparam int SRC_B_LSB = 0;

    typedef enum logic [OPCODE_BITS-1:0] {
        NOP   = 4'd0,
        MOVIR = 4'd1,
        MOVRR = 4'd2,
        LOAD  = 4'd3,
        STORE = 4'd4,
        ADDRR = 4'd5,
        ADDI  = 4'd6,
        SUBRR = 4'd7,
        SUBI  = 4'd8,
        JZI   = 4'd9,
        JZR   = 4'd10,
        HALT  = 4'd15
    } opcode_t;

    // Register write source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_IMM  = 2'd1,
        WB_LOAD = 2'd2
    } wb_sel_t;

    // ALU operand B source
    typedef enum logic {
        B_REG = 1'b0,
        B_IMM = 1'b1
    } b_sel_t;

endpackage

//--- logic/alu.sv
module alu #(
    parameter int DATA_BITS = 8
) (
    input  logic [DATA_BITS-1:0] a,
    input  logic [DATA_BITS-1:0] reg_b,
    input  logic [DATA_BITS-1:0] imm,
    input  cpu_pkg::b_sel_t      b_sel,
    input  logic                 subtract,
    output logic [DATA_BITS-1:0] result,
    output logic                 zero
);

    logic [DATA_BITS-1:0] operand_b;

    assign operand_b = (b_sel == cpu_pkg::B_IMM) ? imm : reg_b;

    // Wraps modulo 2**DATA_BITS and drops the carry
    always_comb begin
        if (subtract) begin
            result = a - operand_b;
        end else begin
            result = a + operand_b;
        end
    end

    assign zero = (result == '0);

endmodule

//--- logic/register_file.sv
module register_file #(
    parameter int DATA_BITS = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] rd0_addr,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] rd1_addr,
    output logic [DATA_BITS-1:0]              rd0_data,
    output logic [DATA_BITS-1:0]              rd1_data,
    input  logic                              wr_en,
    input  logic [cpu_pkg::REG_ADDR_BITS-1:0] wr_addr,
    input  cpu_pkg::wb_sel_t                  wb_sel,
    input  logic [DATA_BITS-1:0]              alu_result,
    input  logic [DATA_BITS-1:0]              imm,
    input  logic [DATA_BITS-1:0]              load_data
);

    localparam int NUM_REGS = 2 ** cpu_pkg::REG_ADDR_BITS;

    logic [DATA_BITS-1:0] regs [NUM_REGS];
    logic [DATA_BITS-1:0] wr_data;

    // Writeback source
    always_comb begin
        case (wb_sel)
            cpu_pkg::WB_IMM:  wr_data = imm;
            cpu_pkg::WB_LOAD: wr_data = load_data;
            default:          wr_data = alu_result;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd0_data = regs[rd0_addr];
    assign rd1_data = regs[rd1_addr];

    // Control must never ask for the unused source code
    wb_sel_legal: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> (wb_sel inside {cpu_pkg::WB_ALU, cpu_pkg::WB_IMM, cpu_pkg::WB_LOAD})
    );

endmodule

//--- logic/ram.sv
module ram #(
    parameter int DATA_BITS     = 8,
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic                     clk,
    input  logic [MEM_ADDR_BITS-1:0] addr,
    input  logic                     re,
    input  logic                     we,
    input  logic [DATA_BITS-1:0]     wdata,
    output logic [DATA_BITS-1:0]     rdata,
    input  logic                     load_we,
    input  logic [MEM_ADDR_BITS-1:0] load_addr,
    input  logic [DATA_BITS-1:0]     load_data
);

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    logic [DATA_BITS-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    // Read register holds its value while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

    // Program loading only happens while the core is in reset or halted
    port_exclusive: assert property (
        @(posedge clk) !(we && load_we)
    );

endmodule

//--- logic/exec_control.sv
module exec_control #(
    parameter int DATA_BITS     = 8,
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic                              clk,
    input  logic                              reset,
    output logic [MEM_ADDR_BITS-1:0]          mem_addr,
    output logic                              mem_re,
    output logic                              mem_we,
    output logic [DATA_BITS-1:0]              mem_wdata,
    input  logic [DATA_BITS-1:0]              mem_rdata,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rd0_addr,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] rd1_addr,
    input  logic [DATA_BITS-1:0]              rd0_data,
    output logic                              wr_en,
    output logic [cpu_pkg::REG_ADDR_BITS-1:0] wr_addr,
    output cpu_pkg::wb_sel_t                  wb_sel,
    output logic [DATA_BITS-1:0]              imm,
    output logic [DATA_BITS-1:0]              load_data,
    output cpu_pkg::b_sel_t                   b_sel,
    output logic                              subtract,
    input  logic                              alu_zero,
    output logic                              halted
);

    localparam int HALF_BITS = cpu_pkg::INSTR_BITS / 2;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_HI,
        FETCH_LO,
        DECODE,
        EXECUTE,
        LOAD_WB,
        STORE_WR,
        HALTED
    } state_t;

    state_t                         state;
    logic [MEM_ADDR_BITS-1:0]       pc;
    logic [cpu_pkg::INSTR_BITS-1:0] ir;
    logic                           zero_flag;

    cpu_pkg::opcode_t               opcode;
    logic [cpu_pkg::IMM_BITS-1:0]   imm_field;
    logic [MEM_ADDR_BITS-1:0]       addr_field;
    logic                           is_alu_op;
    logic                           take_jump;

    assign opcode     = cpu_pkg::opcode_t'(ir[cpu_pkg::INSTR_BITS-1 -: cpu_pkg::OPCODE_BITS]);
    assign imm_field  = ir[cpu_pkg::IMM_BITS-1:0];
    assign addr_field = MEM_ADDR_BITS'(imm_field);
    assign imm        = DATA_BITS'(imm_field);
    assign take_jump  = (opcode == cpu_pkg::JZI) && zero_flag;

    // Instruction decode into datapath controls
    always_comb begin
        is_alu_op = 1'b0;
        subtract  = 1'b0;
        b_sel     = cpu_pkg::B_REG;
        rd0_addr  = ir[cpu_pkg::DEST_LSB +: cpu_pkg::REG_ADDR_BITS];
        case (opcode)
            cpu_pkg::ADDRR: begin
                is_alu_op = 1'b1;
                rd0_addr  = ir[cpu_pkg::SRC_A_LSB +: cpu_pkg::REG_ADDR_BITS];
            end
            cpu_pkg::SUBRR: begin
                is_alu_op = 1'b1;
                subtract  = 1'b1;
                rd0_addr  = ir[cpu_pkg::SRC_A_LSB +: cpu_pkg::REG_ADDR_BITS];
            end
            // Immediate forms operate on the destination register
            cpu_pkg::ADDI: begin
                is_alu_op = 1'b1;
                b_sel     = cpu_pkg::B_IMM;
            end
            cpu_pkg::SUBI: begin
                is_alu_op = 1'b1;
                subtract  = 1'b1;
                b_sel     = cpu_pkg::B_IMM;
            end
            default: begin
            end
        endcase
    end

    assign rd1_addr = ir[cpu_pkg::SRC_B_LSB +: cpu_pkg::REG_ADDR_BITS];
    assign wr_addr  = ir[cpu_pkg::DEST_LSB +: cpu_pkg::REG_ADDR_BITS];

    always_comb begin
        case (opcode)
            cpu_pkg::MOVIR: wb_sel = cpu_pkg::WB_IMM;
            cpu_pkg::LOAD:  wb_sel = cpu_pkg::WB_LOAD;
            default:        wb_sel = cpu_pkg::WB_ALU;
        endcase
    end

    assign wr_en = ((state == EXECUTE) && (is_alu_op || (opcode == cpu_pkg::MOVIR)))
                 || (state == LOAD_WB);

    // Memory port
    always_comb begin
        mem_addr = pc;
        mem_re   = 1'b0;
        mem_we   = 1'b0;
        case (state)
            FETCH_HI: begin
                mem_re = 1'b1;
            end
            FETCH_LO: begin
                mem_addr = pc + MEM_ADDR_BITS'(1);
                mem_re   = 1'b1;
            end
            EXECUTE: begin
                if (opcode == cpu_pkg::LOAD) begin
                    mem_addr = addr_field;
                    mem_re   = 1'b1;
                end
            end
            STORE_WR: begin
                mem_addr = addr_field;
                mem_we   = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign mem_wdata = rd0_data;
    assign load_data = mem_rdata;
    assign halted    = (state == HALTED);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            pc        <= '0;
            ir        <= '0;
            zero_flag <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    state <= FETCH_HI;
                end
                FETCH_HI: begin
                    state <= FETCH_LO;
                end
                FETCH_LO: begin
                    // High byte from the read issued in FETCH_HI
                    ir[cpu_pkg::INSTR_BITS-1 -: HALF_BITS] <= mem_rdata[HALF_BITS-1:0];
                    state <= DECODE;
                end
                DECODE: begin
                    ir[HALF_BITS-1:0] <= mem_rdata[HALF_BITS-1:0];
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    if (is_alu_op) begin
                        zero_flag <= alu_zero;
                    end
                    if (take_jump) begin
                        pc <= addr_field;
                    end else if (opcode != cpu_pkg::HALT) begin
                        pc <= pc + MEM_ADDR_BITS'(2);
                    end
                    case (opcode)
                        cpu_pkg::LOAD:  state <= LOAD_WB;
                        cpu_pkg::STORE: state <= STORE_WR;
                        cpu_pkg::HALT:  state <= HALTED;
                        default:        state <= FETCH_HI;
                    endcase
                end
                LOAD_WB, STORE_WR: begin
                    state <= FETCH_HI;
                end
                HALTED: begin
                    state <= HALTED;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // A read and a write on the shared RAM port never overlap
    mem_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_re && mem_we)
    );

    // Once halted, the core stays quiet until reset
    halted_quiet: assert property (
        @(posedge clk) disable iff (reset)
        halted |-> !wr_en && !mem_we
    );

endmodule

//--- logic/cpu_top.sv
module cpu_top #(
    parameter int DATA_BITS     = 8,
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     load_we,
    input  logic [MEM_ADDR_BITS-1:0] load_addr,
    input  logic [DATA_BITS-1:0]     load_data,
    output logic                     store_valid,
    output logic [MEM_ADDR_BITS-1:0] store_addr,
    output logic [DATA_BITS-1:0]     store_data,
    output logic                     halted
);

    logic [MEM_ADDR_BITS-1:0]          mem_addr;
    logic                              mem_re;
    logic                              mem_we;
    logic [DATA_BITS-1:0]              mem_wdata;
    logic [DATA_BITS-1:0]              mem_rdata;
    logic [cpu_pkg::REG_ADDR_BITS-1:0] rd0_addr;
    logic [cpu_pkg::REG_ADDR_BITS-1:0] rd1_addr;
    logic [DATA_BITS-1:0]              rd0_data;
    logic [DATA_BITS-1:0]              rd1_data;
    logic                              wr_en;
    logic [cpu_pkg::REG_ADDR_BITS-1:0] wr_addr;
    cpu_pkg::wb_sel_t                  wb_sel;
    logic [DATA_BITS-1:0]              imm;
    logic [DATA_BITS-1:0]              core_load_data;
    cpu_pkg::b_sel_t                   b_sel;
    logic                              subtract;
    logic [DATA_BITS-1:0]              alu_result;
    logic                              alu_zero;

    exec_control #(
        .DATA_BITS     (DATA_BITS),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_control (
        .clk       (clk),
        .reset     (reset),
        .mem_addr  (mem_addr),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .rd0_addr  (rd0_addr),
        .rd1_addr  (rd1_addr),
        .rd0_data  (rd0_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wb_sel    (wb_sel),
        .imm       (imm),
        .load_data (core_load_data),
        .b_sel     (b_sel),
        .subtract  (subtract),
        .alu_zero  (alu_zero),
        .halted    (halted)
    );

    alu #(
        .DATA_BITS (DATA_BITS)
    ) u_alu (
        .a        (rd0_data),
        .reg_b    (rd1_data),
        .imm      (imm),
        .b_sel    (b_sel),
        .subtract (subtract),
        .result   (alu_result),
        .zero     (alu_zero)
    );

    register_file #(
        .DATA_BITS (DATA_BITS)
    ) u_regs (
        .clk        (clk),
        .reset      (reset),
        .rd0_addr   (rd0_addr),
        .rd1_addr   (rd1_addr),
        .rd0_data   (rd0_data),
        .rd1_data   (rd1_data),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .imm        (imm),
        .load_data  (core_load_data)
    );

    ram #(
        .DATA_BITS     (DATA_BITS),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_ram (
        .clk       (clk),
        .addr      (mem_addr),
        .re        (mem_re),
        .we        (mem_we),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    // Store observation mirrors the core write port
    assign store_valid = mem_we;
    assign store_addr  = mem_addr;
    assign store_data  = mem_wdata;

endmodule

//--- dv/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

localparam int DEPTH = 2 ** MEM_ADDR_BITS;

function automatic logic [15:0] instr_imm(cpu_pkg::opcode_t op, logic [2:0] rd,
                                          logic [cpu_pkg::IMM_BITS-1:0] k);
    return {op, 1'b0, rd, k};
endfunction

function automatic logic [15:0] instr_rr(cpu_pkg::opcode_t op, logic [2:0] rd,
                                         logic [2:0] ra, logic [2:0] rb);
    return {op, 1'b0, rd, 1'b0, ra, 1'b0, rb};
endfunction

// Unused bytes get an address-derived value
task automatic clear_image();
    for (int a = 0; a < DEPTH; a++) begin
        image[MEM_ADDR_BITS'(a)] = DATA_BITS'(a) ^ DATA_BITS'(8'hC3);
    end
    prog_pc = '0;
endtask

// High byte goes first at the lower address
task automatic emit(logic [15:0] word);
    image[prog_pc] = word[15:8];
    image[prog_pc + MEM_ADDR_BITS'(1)] = word[7:0];
    prog_pc = prog_pc + MEM_ADDR_BITS'(2);
endtask

// ISA model that queues every expected store and returns their count
function automatic int run_reference();
    logic [DATA_BITS-1:0]     mem [DEPTH];
    logic [DATA_BITS-1:0]     regs [8];
    logic [MEM_ADDR_BITS-1:0] pc;
    logic [15:0]              ir;
    logic [3:0]               op;
    logic [DATA_BITS-1:0]     res;
    logic [7:0]               k;
    logic                     zf;
    int                       count;
    mem = image;
    regs = '{default: '0};
    pc = '0;
    zf = 1'b0;
    count = 0;
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int steps = 0; steps < 1000; steps++) begin
        ir = {mem[pc], mem[pc + MEM_ADDR_BITS'(1)]};
        op = ir[15:12];
        k = ir[7:0];
        pc = pc + MEM_ADDR_BITS'(2);
        case (op)
            cpu_pkg::MOVIR: regs[ir[10:8]] = k;
            cpu_pkg::LOAD:  regs[ir[10:8]] = mem[k];
            cpu_pkg::STORE: begin
                mem[k] = regs[ir[10:8]];
                exp_addr_q.push_back(k);
                exp_data_q.push_back(regs[ir[10:8]]);
                count++;
            end
            cpu_pkg::ADDRR, cpu_pkg::SUBRR, cpu_pkg::ADDI, cpu_pkg::SUBI: begin
                case (op)
                    cpu_pkg::ADDRR: res = regs[ir[6:4]] + regs[ir[2:0]];
                    cpu_pkg::SUBRR: res = regs[ir[6:4]] - regs[ir[2:0]];
                    cpu_pkg::ADDI:  res = regs[ir[10:8]] + k;
                    default:        res = regs[ir[10:8]] - k;
                endcase
                regs[ir[10:8]] = res;
                zf = (res == '0);
            end
            cpu_pkg::JZI: begin
                if (zf) begin
                    pc = k;
                end
            end
            cpu_pkg::HALT: return count;
            // MOVRR, JZR and unused codes do nothing
            default: begin
            end
        endcase
    end
    return -1;
endfunction

`endif

//--- dv/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_BITS     = 8;
    localparam int MEM_ADDR_BITS = 8;
    localparam int TIMEOUT       = 2000;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     load_we;
    logic [MEM_ADDR_BITS-1:0] load_addr;
    logic [DATA_BITS-1:0]     load_data;
    logic                     store_valid;
    logic [MEM_ADDR_BITS-1:0] store_addr;
    logic [DATA_BITS-1:0]     store_data;
    logic                     halted;

    logic [DATA_BITS-1:0]     image [2 ** MEM_ADDR_BITS];
    logic [MEM_ADDR_BITS-1:0] prog_pc;
    logic [MEM_ADDR_BITS-1:0] exp_addr_q [$];
    logic [DATA_BITS-1:0]     exp_data_q [$];
    int seed;
    int errors = 0;
    int seen_stores = 0;
    int tests_run = 0;
    int tests_failed = 0;

    `include "cpu_ref.svh"

    cpu_top #(
        .DATA_BITS     (DATA_BITS),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) dut (
        .clk         (clk),
        .reset       (reset),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .halted      (halted)
    );

    always #20 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_addr(logic [MEM_ADDR_BITS-1:0] got, logic [MEM_ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch store_addr: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_data(logic [DATA_BITS-1:0] got, logic [DATA_BITS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch store_data: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    // Store monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && store_valid) begin
            seen_stores++;
            if (exp_addr_q.size() == 0) begin
                $display("unexpected store of %h to address %h", store_data, store_addr);
                errors++;
            end else begin
                check_addr(store_addr, exp_addr_q.pop_front());
                check_data(store_data, exp_data_q.pop_front());
            end
        end
    end

    task automatic build_store_program();
        clear_image();
        for (int i = 0; i < 8; i++) begin
            emit(instr_imm(cpu_pkg::MOVIR, 3'(i), DATA_BITS'($random(seed))));
        end
        for (int i = 0; i < 8; i++) begin
            emit(instr_imm(cpu_pkg::STORE, 3'(i), 8'h90 + 8'(i)));
        end
        emit(instr_imm(cpu_pkg::HALT, 3'd0, 8'h00));
    endtask

    task automatic build_arith_program();
        logic [7:0] base;
        clear_image();
        for (int r = 0; r < 3; r++) begin
            base = 8'h80 + 8'(4 * r);
            emit(instr_imm(cpu_pkg::MOVIR, 3'd1, DATA_BITS'($random(seed))));
            emit(instr_imm(cpu_pkg::MOVIR, 3'd2, DATA_BITS'($random(seed))));
            emit(instr_rr(cpu_pkg::ADDRR, 3'd3, 3'd1, 3'd2));
            emit(instr_imm(cpu_pkg::STORE, 3'd3, base));
            emit(instr_rr(cpu_pkg::SUBRR, 3'd4, 3'd1, 3'd2));
            emit(instr_imm(cpu_pkg::STORE, 3'd4, base + 8'd1));
            emit(instr_imm(cpu_pkg::ADDI, 3'd1, DATA_BITS'($random(seed))));
            emit(instr_imm(cpu_pkg::STORE, 3'd1, base + 8'd2));
            emit(instr_imm(cpu_pkg::SUBI, 3'd2, DATA_BITS'($random(seed))));
            emit(instr_imm(cpu_pkg::STORE, 3'd2, base + 8'd3));
        end
        emit(instr_imm(cpu_pkg::HALT, 3'd0, 8'h00));
    endtask

    task automatic build_load_program();
        clear_image();
        for (int i = 0; i < 4; i++) begin
            image[8'hF0 + MEM_ADDR_BITS'(i)] = DATA_BITS'($random(seed));
        end
        emit(instr_imm(cpu_pkg::LOAD, 3'd1, 8'hF0));
        emit(instr_imm(cpu_pkg::LOAD, 3'd2, 8'hF1));
        emit(instr_rr(cpu_pkg::ADDRR, 3'd3, 3'd1, 3'd2));
        emit(instr_imm(cpu_pkg::STORE, 3'd3, 8'hF0));
        emit(instr_imm(cpu_pkg::ADDI, 3'd2, 8'h11));
        emit(instr_imm(cpu_pkg::STORE, 3'd2, 8'hF1));
        // Reads back a byte the core just wrote
        emit(instr_imm(cpu_pkg::LOAD, 3'd5, 8'hF0));
        emit(instr_imm(cpu_pkg::LOAD, 3'd6, 8'hF3));
        emit(instr_rr(cpu_pkg::SUBRR, 3'd7, 3'd5, 3'd6));
        emit(instr_imm(cpu_pkg::STORE, 3'd5, 8'hE0));
        emit(instr_imm(cpu_pkg::STORE, 3'd7, 8'hE1));
        emit(instr_imm(cpu_pkg::HALT, 3'd0, 8'h00));
    endtask

    task automatic build_jump_program();
        logic [MEM_ADDR_BITS-1:0] skip;
        clear_image();
        emit(instr_imm(cpu_pkg::MOVIR, 3'd1, 8'h05));
        emit(instr_imm(cpu_pkg::MOVIR, 3'd2, 8'h05));
        emit(instr_rr(cpu_pkg::SUBRR, 3'd3, 3'd1, 3'd2));
        emit(instr_imm(cpu_pkg::STORE, 3'd3, 8'hA3));
        skip = prog_pc + MEM_ADDR_BITS'(4);
        emit(instr_imm(cpu_pkg::JZI, 3'd0, skip));
        emit(instr_imm(cpu_pkg::STORE, 3'd1, 8'hA0));
        emit(instr_imm(cpu_pkg::MOVIR, 3'd4, 8'h07));
        emit(instr_rr(cpu_pkg::SUBRR, 3'd5, 3'd4, 3'd1));
        emit(instr_imm(cpu_pkg::JZI, 3'd0, 8'h60));
        emit(instr_imm(cpu_pkg::STORE, 3'd5, 8'hA1));
        emit(instr_imm(cpu_pkg::HALT, 3'd0, 8'h00));
        prog_pc = 8'h60;
        emit(instr_imm(cpu_pkg::STORE, 3'd4, 8'hA2));
        emit(instr_imm(cpu_pkg::HALT, 3'd0, 8'h00));
    endtask

    task automatic build_idle_program();
        clear_image();
        emit(instr_imm(cpu_pkg::MOVIR, 3'd1, 8'h09));
        // Zero flag set so a JZR taken as a jump would leave the program
        emit(instr_rr(cpu_pkg::SUBRR, 3'd3, 3'd2, 3'd2));
        emit(instr_imm(cpu_pkg::NOP, 3'd0, 8'h00));
        emit(instr_rr(cpu_pkg::MOVRR, 3'd1, 3'd2, 3'd3));
        emit(instr_rr(cpu_pkg::JZR, 3'd0, 3'd1, 3'd0));
        emit(instr_imm(cpu_pkg::STORE, 3'd1, 8'hB1));
        emit(instr_imm(cpu_pkg::HALT, 3'd0, 8'h00));
        emit(instr_imm(cpu_pkg::STORE, 3'd1, 8'hB0));
    endtask

    // Loads the image during reset, runs to HALT, then optionally watches a quiet period
    task automatic run_test(string name, int quiet_cycles);
        int err_before;
        int cycles;
        int stores_at_halt;
        err_before = errors;
        tests_run++;
        if (run_reference() < 0) begin
            $display("reference model never reached HALT in %s", name);
            errors++;
        end
        reset = 1'b1;
        repeat (10) step();
        for (int a = 0; a < DEPTH; a++) begin
            load_we = 1'b1;
            load_addr = MEM_ADDR_BITS'(a);
            load_data = image[MEM_ADDR_BITS'(a)];
            step();
        end
        load_we = 1'b0;
        step();
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles in %s", TIMEOUT, name);
            errors++;
        end
        stores_at_halt = seen_stores;
        repeat (quiet_cycles) @(negedge clk);
        if (seen_stores != stores_at_halt) begin
            $display("core wrote memory after it halted in %s", name);
            errors++;
        end
        if (quiet_cycles > 0 && !halted) begin
            $display("halted dropped before reset in %s", name);
            errors++;
        end
        step();
        if (exp_addr_q.size() != 0) begin
            $display("%0d expected stores never appeared in %s", exp_addr_q.size(), name);
            errors++;
        end
        if (errors != err_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, (errors == err_before) ? "passed" : "failed");
    endtask

    initial begin
        reset = 1'b1;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed = 71;
        build_store_program();
        run_test("immediate and store", 0);
        build_arith_program();
        run_test("register and immediate arithmetic", 0);
        build_load_program();
        run_test("load path", 0);
        build_jump_program();
        run_test("conditional jump", 0);
        build_idle_program();
        run_test("halt and idle codes", 50);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+dv
logic/cpu_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/ram.sv
logic/exec_control.sv
logic/cpu_top.sv
dv/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(BUILD_DIR)
